//--- logic/arithmeticUnit.sv
module arithmeticUnit
(
	input logic clock_i,
	input logic reset_i,
	input logic writeEnable_i,
	input coreIsaPkg::regAddr_t dest_i,
	input coreIsaPkg::opcode_t op_i,
	input coreIsaPkg::word_t primValue_i,
	input coreIsaPkg::word_t secReg_i,
	input logic secIsImm_i,
	input coreIsaPkg::word_t imm_i,
	output logic wbEnable_o,
	output coreIsaPkg::regAddr_t wbAddr_o,
	output coreIsaPkg::word_t wbData_o
);
	import coreIsaPkg::*;

	// operand capture stage
	logic capEnable;
	regAddr_t capDest;
	opcode_t capOp;
	word_t capPrim;
	word_t capSec;
	word_t result;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			capEnable <= 1'b0;
		else
			capEnable <= writeEnable_i;
	end

	// secondary operand resolved before capture
	always_ff @(posedge clock_i)
	begin
		capDest <= dest_i;
		capOp <= op_i;
		capPrim <= primValue_i;
		capSec <= secIsImm_i ? imm_i : secReg_i;
	end

	// execute, everything wraps at 16 bits
	always_comb
	begin
		case (capOp)
			ADD: result = capPrim + capSec;
			SUB: result = capPrim - capSec;
			AND: result = capPrim & capSec;
			OR: result = capPrim | capSec;
			XOR: result = capPrim ^ capSec;
			MOV: result = capSec;
			SHL: result = capPrim << capSec[shiftWidth-1:0];
			default: result = '0;
		endcase
	end

	// result stage, drives writeback
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			wbEnable_o <= 1'b0;
		else
			wbEnable_o <= capEnable;
	end

	always_ff @(posedge clock_i)
	begin
		wbAddr_o <= capDest;
		wbData_o <= result;
	end

endmodule

//--- logic/axiProgramPort.sv
module axiProgramPort
(
	input logic clock_i,
	input logic reset_i,
	input logic busy_i,
	// write address and write data
	input coreBusPkg::axiAddr_t awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input coreBusPkg::axiData_t wdata_i,
	input logic wvalid_i,
	output logic wready_o,
	// write response
	output logic bvalid_o,
	input logic bready_i,
	output coreBusPkg::axiResp_t bresp_o,
	// read address and read data
	input coreBusPkg::axiAddr_t araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic rvalid_o,
	input logic rready_i,
	output coreBusPkg::axiData_t rdata_o,
	output coreBusPkg::axiResp_t rresp_o,
	// towards the fetch unit
	output logic imemWrite_o,
	output logic [coreIsaPkg::pcWidth-1:0] imemWriteAddr_o,
	output coreIsaPkg::bundle_t imemWriteData_o,
	output logic start_o,
	output logic [coreIsaPkg::pcWidth-1:0] programLength_o
);
	import coreBusPkg::*;
	import coreIsaPkg::*;

	logic writeAccept;
	logic readAccept;
	logic toCtrl;
	logic toImem;

	//////////////////////////////////////////////////
	// write path

	// aw and w taken in the same cycle, never while bvalid is held
	assign writeAccept = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = writeAccept;
	assign wready_o = writeAccept;

	// address decode
	assign toCtrl = (awaddr_i == ctrlAddr);
	assign toImem = (awaddr_i < ctrlAddr);

	assign bresp_o = respOkay;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			bvalid_o <= 1'b0;
			imemWrite_o <= 1'b0;
			start_o <= 1'b0;
		end
		else
		begin
			// single cycle strobes towards fetch
			imemWrite_o <= writeAccept && toImem;
			start_o <= writeAccept && toCtrl;
			// response held until the master takes it
			if (writeAccept)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
		end
	end

	// payload captured with the accepted write
	always_ff @(posedge clock_i)
	begin
		if (writeAccept)
		begin
			// word index, upper aliases fold onto the bundle memory
			imemWriteAddr_o <= awaddr_i[wordShift +: pcWidth];
			imemWriteData_o <= wdata_i;
			programLength_o <= wdata_i[pcWidth-1:0];
		end
	end

	//////////////////////////////////////////////////
	// read path

	// one read outstanding at most
	assign arready_o = !rvalid_o;
	assign readAccept = arvalid_i && arready_o;
	assign rresp_o = respOkay;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			rvalid_o <= 1'b0;
		else if (readAccept)
			rvalid_o <= 1'b1;
		else if (rready_i)
			rvalid_o <= 1'b0;
	end

	// status word, busy in bit 0, zero elsewhere in the map
	always_ff @(posedge clock_i)
	begin
		if (readAccept)
			rdata_o <= (araddr_i == ctrlAddr) ? axiData_t'(busy_i) : '0;
	end

endmodule

//--- logic/coreBusPkg.sv
package coreBusPkg;

	// AXI4-Lite sizes
	localparam int axiAddrWidth = 12;
	localparam int axiDataWidth = 32;

	typedef logic [axiAddrWidth-1:0] axiAddr_t;
	typedef logic [axiDataWidth-1:0] axiData_t;
	typedef logic [1:0] axiResp_t;

	// only okay is ever returned
	localparam axiResp_t respOkay = 2'b00;

	//////////////////////////////////////////////////
	// address map

	// control register, busy flag on read
	localparam axiAddr_t ctrlAddr = 12'h800;
	// below ctrlAddr, one bundle per 32-bit word
	localparam int wordShift = 2;

endpackage

//--- logic/coreIsaPkg.sv
package coreIsaPkg;

	// datapath sizes
	localparam int wordWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int regCount = 2 ** regAddrWidth;
	// secondary field of an instruction
	localparam int immWidth = 8;
	// shift amount taken from the low bits of the secondary operand
	localparam int shiftWidth = 4;
	// program counter and program length
	localparam int pcWidth = 8;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// nop writes nothing, mov copies the secondary operand
	typedef enum logic [2:0]
	{
		NOP = 3'd0,
		ADD = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		OR = 3'd4,
		XOR = 3'd5,
		MOV = 3'd6,
		SHL = 3'd7
	} opcode_t;

	// 15:13 opcode, 12 format, 11:8 primary reg, 7:0 secondary field
	typedef struct packed
	{
		opcode_t opcode;
		// 0 reg-reg, 1 reg-imm
		logic isImm;
		regAddr_t primReg;
		logic [immWidth-1:0] secField;
	} instr_t;

	// lane A sits in the upper half
	typedef struct packed
	{
		instr_t laneA;
		instr_t laneB;
	} bundle_t;

endpackage

//--- logic/fetchUnit.sv
module fetchUnit
#(
	parameter int imemDepth = 256
)
(
	input logic clock_i,
	input logic reset_i,
	// bundle writes from the program port
	input logic imemWrite_i,
	input logic [coreIsaPkg::pcWidth-1:0] imemWriteAddr_i,
	input coreIsaPkg::bundle_t imemWriteData_i,
	// run request
	input logic start_i,
	input logic [coreIsaPkg::pcWidth-1:0] programLength_i,
	output logic busy_o,
	output logic bundleValid_o,
	output coreIsaPkg::bundle_t bundle_o,
	output logic [coreIsaPkg::pcWidth-1:0] pc_o
);
	import coreIsaPkg::*;

	localparam int imemAddrWidth = $clog2(imemDepth);

	bundle_t imem [imemDepth];
	// index of the final bundle of the run
	logic [pcWidth-1:0] lastPc;
	logic lastIssue;

	// instruction memory write port
	always_ff @(posedge clock_i)
	begin
		if (imemWrite_i)
			imem[imemWriteAddr_i[imemAddrWidth-1:0]] <= imemWriteData_i;
	end

	assign lastIssue = busy_o && (pc_o == lastPc);

	//////////////////////////////////////////////////
	// run control

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			busy_o <= 1'b0;
			bundleValid_o <= 1'b0;
			pc_o <= '0;
		end
		else
		begin
			// one bundle issued per busy cycle
			bundleValid_o <= busy_o;
			if (busy_o)
			begin
				pc_o <= pc_o + 1'b1;
				if (lastIssue)
					busy_o <= 1'b0;
			end
			else if (start_i)
			begin
				// zero length starts nothing
				pc_o <= '0;
				busy_o <= (programLength_i != '0);
			end
		end
	end

	// end index latched at start, start is ignored while busy
	always_ff @(posedge clock_i)
	begin
		if (start_i && !busy_o)
			lastPc <= programLength_i - 1'b1;
	end

	// registered bundle read at the fetch pc
	always_ff @(posedge clock_i)
	begin
		if (busy_o)
			bundle_o <= imem[pc_o[imemAddrWidth-1:0]];
	end

endmodule

//--- logic/laneDecoder.sv
module laneDecoder
(
	input coreIsaPkg::instr_t instr_i,
	input logic valid_i,
	output logic writeEnable_o,
	output coreIsaPkg::regAddr_t dest_o,
	output coreIsaPkg::regAddr_t srcReg_o,
	output logic secIsImm_o,
	output coreIsaPkg::word_t imm_o,
	output coreIsaPkg::opcode_t op_o
);
	import coreIsaPkg::*;

	//////////////////////////////////////////////////
	// field split

	// two-address form, primary reg is read and written
	assign dest_o = instr_i.primReg;

	// reg-reg form names a register in the low nibble
	assign srcReg_o = instr_i.secField[regAddrWidth-1:0];

	// format bit picks the immediate over the register
	assign secIsImm_o = instr_i.isImm;

	// immediate is zero extended
	assign imm_o = word_t'(instr_i.secField);

	assign op_o = instr_i.opcode;

	//////////////////////////////////////////////////
	// write qualification

	// empty slot or nop never reaches writeback
	assign writeEnable_o = valid_i && (instr_i.opcode != NOP);

endmodule

//--- logic/paCore.sv
module paCore
#(
	parameter int imemDepth = 256
)
(
	input logic clock_i,
	input logic reset_i,
	// AXI4-Lite slave
	input coreBusPkg::axiAddr_t awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input coreBusPkg::axiData_t wdata_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic bvalid_o,
	input logic bready_i,
	output coreBusPkg::axiResp_t bresp_o,
	input coreBusPkg::axiAddr_t araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic rvalid_o,
	input logic rready_i,
	output coreBusPkg::axiData_t rdata_o,
	output coreBusPkg::axiResp_t rresp_o,
	// fetch pc
	output logic [coreIsaPkg::pcWidth-1:0] pc_o,
	// writeback, one port per lane
	output logic wbEnableA_o,
	output coreIsaPkg::regAddr_t wbAddrA_o,
	output coreIsaPkg::word_t wbDataA_o,
	output logic wbEnableB_o,
	output coreIsaPkg::regAddr_t wbAddrB_o,
	output coreIsaPkg::word_t wbDataB_o
);
	import coreIsaPkg::*;

	// program port to fetch
	logic busy;
	logic imemWrite;
	logic [pcWidth-1:0] imemWriteAddr;
	bundle_t imemWriteData;
	logic start;
	logic [pcWidth-1:0] programLength;

	// fetched bundle
	logic bundleValid;
	bundle_t bundle;

	// decoded lane A
	logic writeEnableA;
	regAddr_t destA;
	regAddr_t srcRegA;
	logic secIsImmA;
	word_t immA;
	opcode_t opA;

	// decoded lane B
	logic writeEnableB;
	regAddr_t destB;
	regAddr_t srcRegB;
	logic secIsImmB;
	word_t immB;
	opcode_t opB;

	// register reads
	word_t readDataPrimA;
	word_t readDataSecA;
	word_t readDataPrimB;
	word_t readDataSecB;

	//////////////////////////////////////////////////
	// program load and fetch

	axiProgramPort programPort_inst
	(
		.clock_i(clock_i), .reset_i(reset_i), .busy_i(busy),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bvalid_o(bvalid_o), .bready_i(bready_i), .bresp_o(bresp_o),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o), .rresp_o(rresp_o),
		.imemWrite_o(imemWrite), .imemWriteAddr_o(imemWriteAddr),
		.imemWriteData_o(imemWriteData),
		.start_o(start), .programLength_o(programLength)
	);

	fetchUnit #(.imemDepth(imemDepth)) fetch_inst
	(
		.clock_i(clock_i), .reset_i(reset_i),
		.imemWrite_i(imemWrite), .imemWriteAddr_i(imemWriteAddr),
		.imemWriteData_i(imemWriteData),
		.start_i(start), .programLength_i(programLength),
		.busy_o(busy), .bundleValid_o(bundleValid), .bundle_o(bundle), .pc_o(pc_o)
	);

	//////////////////////////////////////////////////
	// decode and register read

	laneDecoder decoderA_inst
	(
		.instr_i(bundle.laneA), .valid_i(bundleValid),
		.writeEnable_o(writeEnableA), .dest_o(destA), .srcReg_o(srcRegA),
		.secIsImm_o(secIsImmA), .imm_o(immA), .op_o(opA)
	);

	laneDecoder decoderB_inst
	(
		.instr_i(bundle.laneB), .valid_i(bundleValid),
		.writeEnable_o(writeEnableB), .dest_o(destB), .srcReg_o(srcRegB),
		.secIsImm_o(secIsImmB), .imm_o(immB), .op_o(opB)
	);

	// writeback ports close the loop into the register file
	registerFile regFile_inst
	(
		.clock_i(clock_i), .reset_i(reset_i),
		.readAddrPrimA_i(destA), .readAddrSecA_i(srcRegA),
		.readAddrPrimB_i(destB), .readAddrSecB_i(srcRegB),
		.writeEnableA_i(wbEnableA_o), .writeAddrA_i(wbAddrA_o), .writeDataA_i(wbDataA_o),
		.writeEnableB_i(wbEnableB_o), .writeAddrB_i(wbAddrB_o), .writeDataB_i(wbDataB_o),
		.readDataPrimA_o(readDataPrimA), .readDataSecA_o(readDataSecA),
		.readDataPrimB_o(readDataPrimB), .readDataSecB_o(readDataSecB)
	);

	//////////////////////////////////////////////////
	// execute lanes

	arithmeticUnit aluA_inst
	(
		.clock_i(clock_i), .reset_i(reset_i),
		.writeEnable_i(writeEnableA), .dest_i(destA), .op_i(opA),
		.primValue_i(readDataPrimA), .secReg_i(readDataSecA),
		.secIsImm_i(secIsImmA), .imm_i(immA),
		.wbEnable_o(wbEnableA_o), .wbAddr_o(wbAddrA_o), .wbData_o(wbDataA_o)
	);

	arithmeticUnit aluB_inst
	(
		.clock_i(clock_i), .reset_i(reset_i),
		.writeEnable_i(writeEnableB), .dest_i(destB), .op_i(opB),
		.primValue_i(readDataPrimB), .secReg_i(readDataSecB),
		.secIsImm_i(secIsImmB), .imm_i(immB),
		.wbEnable_o(wbEnableB_o), .wbAddr_o(wbAddrB_o), .wbData_o(wbDataB_o)
	);

endmodule

//--- logic/registerFile.sv
module registerFile
(
	input logic clock_i,
	input logic reset_i,
	// read ports, two per lane
	input coreIsaPkg::regAddr_t readAddrPrimA_i,
	input coreIsaPkg::regAddr_t readAddrSecA_i,
	input coreIsaPkg::regAddr_t readAddrPrimB_i,
	input coreIsaPkg::regAddr_t readAddrSecB_i,
	// write ports from the two lanes
	input logic writeEnableA_i,
	input coreIsaPkg::regAddr_t writeAddrA_i,
	input coreIsaPkg::word_t writeDataA_i,
	input logic writeEnableB_i,
	input coreIsaPkg::regAddr_t writeAddrB_i,
	input coreIsaPkg::word_t writeDataB_i,
	output coreIsaPkg::word_t readDataPrimA_o,
	output coreIsaPkg::word_t readDataSecA_o,
	output coreIsaPkg::word_t readDataPrimB_o,
	output coreIsaPkg::word_t readDataSecB_o
);
	import coreIsaPkg::*;

	word_t regs [regCount];

	//////////////////////////////////////////////////
	// write side

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (writeEnableA_i)
				regs[writeAddrA_i] <= writeDataA_i;
			// lane B last, so it wins a clash on the same register
			if (writeEnableB_i)
				regs[writeAddrB_i] <= writeDataB_i;
		end
	end

	//////////////////////////////////////////////////
	// read side

	// plain array reads, a write shows up the cycle after its edge
	assign readDataPrimA_o = regs[readAddrPrimA_i];
	assign readDataSecA_o = regs[readAddrSecA_i];
	assign readDataPrimB_o = regs[readAddrPrimB_i];
	assign readDataSecB_o = regs[readAddrSecB_i];

endmodule

//--- sources.f
logic/coreIsaPkg.sv
logic/coreBusPkg.sv
logic/axiProgramPort.sv
logic/fetchUnit.sv
logic/laneDecoder.sv
logic/registerFile.sv
logic/arithmeticUnit.sv
logic/paCore.sv
verification/paCoreTb.sv

//--- verification/paCoreTb.sv
module paCoreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import coreIsaPkg::*;
	import coreBusPkg::*;

	// one expected or pending lane write
	typedef struct packed
	{
		logic en;
		regAddr_t addr;
		word_t data;
	} write_t;

	logic clock = 1'b0;
	logic reset;
	axiAddr_t awaddr;
	logic awvalid;
	logic awready;
	axiData_t wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	axiResp_t bresp;
	axiAddr_t araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	axiData_t rdata;
	axiResp_t rresp;
	logic [pcWidth-1:0] pc;
	logic wbEnableA;
	regAddr_t wbAddrA;
	word_t wbDataA;
	logic wbEnableB;
	regAddr_t wbAddrB;
	word_t wbDataB;

	// reference state
	word_t modelRegs [regCount];
	write_t pendA [2];
	write_t pendB [2];
	write_t expA [$];
	write_t expB [$];
	bundle_t programBundles [$];

	logic [31:0] rngState = 32'h6219_3ea3;
	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int bundlesLoaded = 0;

	paCore paCore_inst
	(
		.clock_i(clock), .reset_i(reset),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
		.bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
		.rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
		.pc_o(pc),
		.wbEnableA_o(wbEnableA), .wbAddrA_o(wbAddrA), .wbDataA_o(wbDataA),
		.wbEnableB_o(wbEnableB), .wbAddrB_o(wbAddrB), .wbDataB_o(wbDataB)
	);

	// 20 ns period
	always #10 clock = ~clock;

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	//////////////////////////////////////////////////
	// reference model

	// one lane against the visible register state
	function automatic word_t laneResult(input instr_t ins);
		word_t prim;
		word_t sec;
		prim = modelRegs[ins.primReg];
		sec = ins.isImm ? word_t'(ins.secField) : modelRegs[ins.secField[3:0]];
		case (ins.opcode)
			ADD: return prim + sec;
			SUB: return prim - sec;
			AND: return prim & sec;
			OR: return prim | sec;
			XOR: return prim ^ sec;
			MOV: return sec;
			SHL: return prim << sec[3:0];
			default: return '0;
		endcase
	endfunction

	function automatic void commitWrite(input write_t w);
		if (w.en)
			modelRegs[w.addr] = w.data;
	endfunction

	// bundle i sees bundles up to i-3 and lane B never sees lane A of its own bundle
	function automatic void applyBundle(input bundle_t b);
		write_t wa;
		write_t wb;
		wa.en = (b.laneA.opcode != NOP);
		wa.addr = b.laneA.primReg;
		wa.data = laneResult(b.laneA);
		wb.en = (b.laneB.opcode != NOP);
		wb.addr = b.laneB.primReg;
		wb.data = laneResult(b.laneB);
		if (wa.en)
			expA.push_back(wa);
		if (wb.en)
			expB.push_back(wb);
		// bundle i-2 becomes visible to i+1 with lane B last so it wins
		commitWrite(pendA[0]);
		commitWrite(pendB[0]);
		pendA[0] = pendA[1];
		pendB[0] = pendB[1];
		pendA[1] = wa;
		pendB[1] = wb;
	endfunction

	// everything lands before the next start
	function automatic void flushModel();
		for (int i = 0; i < 2; i++)
		begin
			commitWrite(pendA[i]);
			commitWrite(pendB[i]);
			pendA[i] = '0;
			pendB[i] = '0;
		end
	endfunction

	//////////////////////////////////////////////////
	// checks

	task automatic checkWrite(input regAddr_t gotAddr, input word_t gotData,
		input write_t expected, input string lane);
		if (gotAddr !== expected.addr || gotData !== expected.data)
		begin
			valueErrors++;
			$display("[FAIL] %0t: lane %s wrote r%0d=%h, expected r%0d=%h", $time, lane,
				gotAddr, gotData, expected.addr, expected.data);
		end
	endtask

	task automatic checkResp(input axiResp_t got, input string what);
		if (got !== respOkay)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %b, expected OKAY", $time, what, got);
		end
	endtask

	task automatic checkStatus(input axiData_t got, input axiData_t expected, input string what);
		if (got !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkPc(input logic [pcWidth-1:0] got, input logic [pcWidth-1:0] expected,
		input string what);
		if (got !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// writeback ports sampled mid-cycle
	always @(negedge clock)
	begin
		write_t expected;
		if (wbEnableA === 1'b1)
		begin
			if (expA.size() == 0)
			begin
				otherErrors++;
				$display("lane A wrote r%0d at %0t but no write was expected", wbAddrA, $time);
			end
			else
			begin
				expected = expA.pop_front();
				checkWrite(wbAddrA, wbDataA, expected, "A");
			end
		end
		if (wbEnableB === 1'b1)
		begin
			if (expB.size() == 0)
			begin
				otherErrors++;
				$display("lane B wrote r%0d at %0t but no write was expected", wbAddrB, $time);
			end
			else
			begin
				expected = expB.pop_front();
				checkWrite(wbAddrB, wbDataB, expected, "B");
			end
		end
	end

	// limit grows with every bundle loaded
	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > 40 * bundlesLoaded + 2000)
		begin
			$display("timeout after %0d cycles with %0d lane A and %0d lane B writes missing",
				cycleCount, expA.size(), expB.size());
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// bus tasks

	task automatic axiWrite(input axiAddr_t addr, input axiData_t data);
		int delay;
		@(posedge clock);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		@(negedge clock);
		while (!awready)
			@(negedge clock);
		// taken at this edge
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clock);
		while (!bvalid)
			@(negedge clock);
		// bready held back a few cycles
		delay = nextRandom() % 4;
		repeat (delay + 1)
			@(posedge clock);
		bready <= 1'b1;
		@(negedge clock);
		if (bvalid !== 1'b1)
		begin
			otherErrors++;
			$display("write response dropped at %0t before bready was raised", $time);
		end
		checkResp(bresp, "write response");
		@(posedge clock);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input axiAddr_t addr, output axiData_t data);
		int delay;
		@(posedge clock);
		araddr <= addr;
		arvalid <= 1'b1;
		@(negedge clock);
		while (!arready)
			@(negedge clock);
		@(posedge clock);
		arvalid <= 1'b0;
		@(negedge clock);
		while (!rvalid)
			@(negedge clock);
		delay = nextRandom() % 4;
		repeat (delay + 1)
			@(posedge clock);
		rready <= 1'b1;
		@(negedge clock);
		if (rvalid !== 1'b1)
		begin
			otherErrors++;
			$display("read response dropped at %0t before rready was raised", $time);
		end
		data = rdata;
		checkResp(rresp, "read response");
		@(posedge clock);
		rready <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// programs

	function automatic instr_t mkInstr(input opcode_t op, input logic isImm,
		input regAddr_t prim, input logic [7:0] sec);
		instr_t ins;
		ins.opcode = op;
		ins.isImm = isImm;
		ins.primReg = prim;
		ins.secField = sec;
		return ins;
	endfunction

	function automatic void addBundle(input instr_t a, input instr_t b);
		bundle_t bnd;
		bnd.laneA = a;
		bnd.laneB = b;
		programBundles.push_back(bnd);
	endfunction

	// load, model, start, poll busy, let the pipeline drain
	task automatic runProgram();
		axiData_t status;
		int len;
		len = programBundles.size();
		bundlesLoaded += len;
		for (int i = 0; i < len; i++)
		begin
			axiWrite(axiAddr_t'(i << wordShift), axiData_t'(programBundles[i]));
			applyBundle(programBundles[i]);
		end
		flushModel();
		axiWrite(ctrlAddr, axiData_t'(len));
		axiRead(ctrlAddr, status);
		// long runs are still going at the first poll
		if (len >= 12)
			checkStatus(status, 32'd1, "status early in run");
		while (status !== '0)
		begin
			checkStatus(status, 32'd1, "status while running");
			axiRead(ctrlAddr, status);
		end
		// last bundle reaches writeback two edges after it issues
		repeat (4)
			@(negedge clock);
		// pc stops one past the final bundle
		checkPc(pc, pcWidth'(len), "pc after run");
		if (expA.size() != 0 || expB.size() != 0)
		begin
			otherErrors++;
			$display("run of %0d bundles ended with %0d lane A and %0d lane B writes missing",
				len, expA.size(), expB.size());
			expA.delete();
			expB.delete();
		end
		programBundles.delete();
	endtask

	initial
	begin
		axiData_t status;
		int len;
		reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		for (int i = 0; i < regCount; i++)
			modelRegs[i] = '0;
		pendA[0] = '0;
		pendA[1] = '0;
		pendB[0] = '0;
		pendB[1] = '0;
		repeat (10)
			@(posedge clock);
		reset <= 1'b0;

		// idle after reset
		@(negedge clock);
		if (wbEnableA !== 1'b0 || wbEnableB !== 1'b0 || bvalid !== 1'b0 || rvalid !== 1'b0)
		begin
			valueErrors++;
			$display("[FAIL] %0t: outputs active after reset", $time);
		end
		axiRead(ctrlAddr, status);
		checkStatus(status, 32'd0, "status after reset");
		axiRead(12'h004, status);
		checkStatus(status, 32'd0, "read outside control");

		// every opcode in both formats without hazards
		addBundle(mkInstr(MOV, 1, 1, 8'h12), mkInstr(MOV, 1, 2, 8'h34));
		addBundle(mkInstr(MOV, 1, 3, 8'h56), mkInstr(MOV, 1, 4, 8'h78));
		addBundle(mkInstr(MOV, 1, 5, 8'h9a), mkInstr(MOV, 1, 6, 8'hbc));
		addBundle(mkInstr(MOV, 1, 7, 8'hde), mkInstr(MOV, 1, 8, 8'hf1));
		addBundle(mkInstr(NOP, 0, 0, 8'h00), mkInstr(NOP, 0, 0, 8'h00));
		addBundle(mkInstr(NOP, 0, 0, 8'h00), mkInstr(NOP, 0, 0, 8'h00));
		addBundle(mkInstr(ADD, 0, 1, 8'h02), mkInstr(ADD, 1, 3, 8'h05));
		addBundle(mkInstr(SUB, 0, 4, 8'h05), mkInstr(SUB, 1, 6, 8'h10));
		addBundle(mkInstr(AND, 0, 7, 8'h08), mkInstr(AND, 1, 9, 8'h0f));
		addBundle(mkInstr(OR, 0, 10, 8'h02), mkInstr(OR, 1, 11, 8'ha0));
		addBundle(mkInstr(XOR, 0, 12, 8'h05), mkInstr(XOR, 1, 13, 8'hff));
		addBundle(mkInstr(MOV, 0, 14, 8'h08), mkInstr(MOV, 1, 15, 8'h7e));
		addBundle(mkInstr(SHL, 0, 2, 8'h05), mkInstr(SHL, 1, 8, 8'h03));
		addBundle(mkInstr(NOP, 0, 1, 8'h02), mkInstr(NOP, 1, 3, 8'h44));
		runProgram();

		// same destination from both lanes and then lane B reading lane A's destination
		addBundle(mkInstr(MOV, 1, 1, 8'h11), mkInstr(MOV, 1, 1, 8'h22));
		addBundle(mkInstr(MOV, 1, 5, 8'h33), mkInstr(MOV, 0, 6, 8'h05));
		addBundle(mkInstr(NOP, 0, 0, 8'h00), mkInstr(NOP, 0, 0, 8'h00));
		addBundle(mkInstr(MOV, 0, 2, 8'h01), mkInstr(NOP, 0, 0, 8'h00));
		runProgram();

		// stale reads one and two bundles back
		addBundle(mkInstr(MOV, 1, 7, 8'h05), mkInstr(MOV, 1, 8, 8'h06));
		addBundle(mkInstr(ADD, 1, 7, 8'h01), mkInstr(MOV, 0, 9, 8'h08));
		addBundle(mkInstr(ADD, 0, 10, 8'h07), mkInstr(XOR, 0, 8, 8'h08));
		addBundle(mkInstr(MOV, 0, 11, 8'h07), mkInstr(MOV, 0, 12, 8'h08));
		runProgram();

		// random programs back to back with the state carried over
		for (int run = 0; run < 4; run++)
		begin
			len = 8 + nextRandom() % 24;
			for (int i = 0; i < len; i++)
				programBundles.push_back(bundle_t'(nextRandom()));
			runProgram();
		end

		$display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
